// File: ray_pkg.sv
package ray_pkg;

  // Q16.16 signed fixed point
  typedef logic signed [31:0] fp;

  typedef struct packed {
    fp x;
    fp y;
    fp z;
  } vec3;

  localparam int num_frac_digits = 16;
  localparam int display_width = 320;
  localparam int display_height = 180;
  localparam int h_bits = 9;
  localparam int v_bits = 8;

  localparam fp fp_zero = '0;
  localparam fp fp_one = fp'(1 << num_frac_digits);
  localparam fp fp_half = fp_one >>> 1;
  localparam fp fp_three_halves = fp_one + fp_half;
  localparam fp fp_display_width = fp'(display_width << num_frac_digits);
  localparam fp fp_display_height = fp'(display_height << num_frac_digits);
  // 1/180, truncated
  localparam fp fp_inv_display_height = fp'(fp_one / display_height);

  // looking down +z
  localparam vec3 cam_forward_reset = '{x: fp_zero, y: fp_zero, z: fp_one};

  localparam int inv_sqrt_iters = 4;

  function automatic fp fp_add(fp a, fp b);
    return a + b;
  endfunction

  function automatic fp fp_sub(fp a, fp b);
    return a - b;
  endfunction

  // full 64-bit product, then drop the low fraction bits
  function automatic fp fp_mul(fp a, fp b);
    logic signed [63:0] wide_a;
    logic signed [63:0] wide_b;
    logic signed [63:0] prod;
    wide_a = a;
    wide_b = b;
    prod = wide_a * wide_b;
    return fp'(prod >>> num_frac_digits);
  endfunction

  function automatic vec3 make_vec3(fp x, fp y, fp z);
    vec3 v;
    v.x = x;
    v.y = y;
    v.z = z;
    return v;
  endfunction

  function automatic vec3 vec3_add(vec3 a, vec3 b);
    return make_vec3(fp_add(a.x, b.x), fp_add(a.y, b.y), fp_add(a.z, b.z));
  endfunction

  function automatic vec3 vec3_scaled(vec3 v, fp s);
    return make_vec3(fp_mul(v.x, s), fp_mul(v.y, s), fp_mul(v.z, s));
  endfunction

  function automatic fp vec3_dot(vec3 a, vec3 b);
    return fp_add(fp_add(fp_mul(a.x, b.x), fp_mul(a.y, b.y)), fp_mul(a.z, b.z));
  endfunction

  function automatic vec3 vec3_cross(vec3 a, vec3 b);
    return make_vec3(fp_sub(fp_mul(a.y, b.z), fp_mul(a.z, b.y)),
                     fp_sub(fp_mul(a.z, b.x), fp_mul(a.x, b.z)),
                     fp_sub(fp_mul(a.x, b.y), fp_mul(a.y, b.x)));
  endfunction

endpackage

// File: inv_sqrt_if.sv
interface inv_sqrt_if;
  import ray_pkg::*;

  // operand and launch strobe, from the ray generator
  fp a;
  logic start;

  // result, completion strobe and idle level, from the unit
  fp res;
  logic done;
  logic ready;

  // start only while ready is high
  modport client (output a, output start, input res, input done, input ready);

  modport server (input a, input start, output res, output done, output ready);

endinterface

// File: fp_inv_sqrt_folded.sv
module fp_inv_sqrt_folded (
  input logic clk_in,
  input logic rst_in,
  inv_sqrt_if.server sqrt_bus
);
  import ray_pkg::*;

  logic ready_q;
  logic done_q;
  logic [1:0] phase;
  logic [3:0] iter;
  logic last_iter;

  fp a_half;
  fp y;
  fp t;

  logic [4:0] lead_pos;
  logic [5:0] seed_shift;
  fp seed;

  fp mul_a;
  fp mul_b;
  fp mul_res;

  // position of the highest set bit of the operand
  always_comb begin
    lead_pos = '0;
    for (int i = 0; i < 32; i++) begin
      if (sqrt_bus.a[i]) begin
        lead_pos = 5'(i);
      end
    end
  end

  // a ~ 2^(p-16) so 1/sqrt(a) ~ 2^((16-p)/2), placed above the binary point
  assign seed_shift = (6'd48 - {1'b0, lead_pos}) >> 1;
  assign seed = fp'(32'd1 << seed_shift);

  assign last_iter = (iter == 4'(inv_sqrt_iters - 1));

  // phase 0: y*y, phase 1: (a/2)*y^2, phase 2: y*(3/2 - t)
  always_comb begin
    mul_a = y;
    mul_b = y;
    case (phase)
      2'd1: begin
        mul_a = a_half;
        mul_b = t;
      end
      2'd2: begin
        mul_a = y;
        mul_b = fp_sub(fp_three_halves, t);
      end
      default: ;
    endcase
  end

  assign mul_res = fp_mul(mul_a, mul_b);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ready_q <= 1'b1;
      done_q <= 1'b0;
      phase <= '0;
      iter <= '0;
    end else begin
      done_q <= 1'b0;
      if (ready_q) begin
        if (sqrt_bus.start) begin
          ready_q <= 1'b0;
          phase <= '0;
          iter <= '0;
        end
      end else if (phase == 2'd2) begin
        phase <= '0;
        iter <= iter + 4'd1;
        if (last_iter) begin
          done_q <= 1'b1;
          ready_q <= 1'b1;
        end
      end else begin
        phase <= phase + 2'd1;
      end
    end
  end

  // seed taken on the start edge, then refined in place
  always_ff @(posedge clk_in) begin
    if (ready_q && sqrt_bus.start) begin
      a_half <= sqrt_bus.a >>> 1;
      y <= seed;
    end else if (!ready_q) begin
      if (phase == 2'd2) begin
        y <= mul_res;
      end else begin
        t <= mul_res;
      end
    end
  end

  assign sqrt_bus.res = y;
  assign sqrt_bus.done = done_q;
  assign sqrt_bus.ready = ready_q;

  // client must respect the ready level
  a_start_when_ready: assert property (@(posedge clk_in) disable iff (rst_in)
    sqrt_bus.start |-> sqrt_bus.ready);

  a_done_single: assert property (@(posedge clk_in) disable iff (rst_in)
    sqrt_bus.done |=> !sqrt_bus.done);

endmodule

// File: camera_regs.sv
module camera_regs (
  input logic clk_in,
  input logic rst_in,
  input logic cam_wr_in,
  input ray_pkg::vec3 cam_forward_in,
  input logic gen_ready_in,
  output ray_pkg::vec3 cam_forward_out
);
  import ray_pkg::*;

  vec3 active;
  vec3 pending;
  logic pending_valid;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      active <= cam_forward_reset;
      pending_valid <= 1'b0;
    end else if (gen_ready_in) begin
      // idle: direct writes win over anything parked
      if (cam_wr_in) begin
        active <= cam_forward_in;
        pending_valid <= 1'b0;
      end else if (pending_valid) begin
        active <= pending;
        pending_valid <= 1'b0;
      end
    end else if (cam_wr_in) begin
      pending_valid <= 1'b1;
    end
  end

  // latest write while busy replaces the older one
  always_ff @(posedge clk_in) begin
    if (!gen_ready_in && cam_wr_in) begin
      pending <= cam_forward_in;
    end
  end

  assign cam_forward_out = active;

  // camera basis must not move under a ray in flight
  a_active_frozen: assert property (@(posedge clk_in) disable iff (rst_in)
    !gen_ready_in |=> $stable(active));

endmodule

// File: ray_generator_folded.sv
module ray_generator_folded (
  input logic clk_in,
  input logic rst_in,
  input logic valid_in,
  input logic [ray_pkg::h_bits-1:0] hcount_in,
  input logic [ray_pkg::v_bits-1:0] vcount_in,
  input ray_pkg::vec3 cam_forward_in,
  output logic valid_out,
  output logic ready_out,
  output ray_pkg::vec3 ray_direction_out,
  inv_sqrt_if.client sqrt_bus
);
  import ray_pkg::*;

  logic [2:0] stage;
  logic start_q;

  // stage 0 captures
  fp hcount_fp;
  fp vcount_fp;
  vec3 cam_forward;

  // camera basis
  vec3 cam_right;
  vec3 cam_up;

  // screen coordinates
  fp px;
  fp py;

  vec3 scaled_right;
  vec3 scaled_up;

  // unnormalized direction
  vec3 rd_sum;
  vec3 rd;

  fp mult1_a, mult1_b, mult1_res;
  fp mult2_a, mult2_b, mult2_res;
  fp mult3_a, mult3_b, mult3_res;

  assign rd_sum = vec3_add(vec3_add(scaled_right, scaled_up), cam_forward);

  assign sqrt_bus.a = vec3_dot(rd, rd);
  assign sqrt_bus.start = start_q;

  assign mult1_res = fp_mul(mult1_a, mult1_b);
  assign mult2_res = fp_mul(mult2_a, mult2_b);
  assign mult3_res = fp_mul(mult3_a, mult3_b);

  // shared multiplier operands picked by stage
  always_comb begin
    mult1_a = fp_zero;
    mult1_b = fp_zero;
    mult2_a = fp_zero;
    mult2_b = fp_zero;
    mult3_a = fp_zero;
    mult3_b = fp_zero;
    case (stage)
      3'd3: begin
        mult1_a = fp_sub(hcount_fp, fp_display_width);
        mult1_b = fp_inv_display_height;
        mult2_a = fp_sub(vcount_fp, fp_display_height);
        mult2_b = fp_inv_display_height;
      end
      3'd4: begin
        mult1_a = cam_right.x;
        mult1_b = px;
        mult2_a = cam_right.y;
        mult2_b = px;
        mult3_a = cam_right.z;
        mult3_b = px;
      end
      3'd6: begin
        mult1_a = rd.x;
        mult1_b = sqrt_bus.res;
        mult2_a = rd.y;
        mult2_b = sqrt_bus.res;
        mult3_a = rd.z;
        mult3_b = sqrt_bus.res;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      stage <= 3'd0;
      valid_out <= 1'b0;
      ready_out <= 1'b1;
      start_q <= 1'b0;
    end else begin
      case (stage)
        3'd0: begin
          if (valid_in) begin
            valid_out <= 1'b0;
            ready_out <= 1'b0;
            stage <= 3'd1;
          end
        end
        3'd1, 3'd2, 3'd3, 3'd4: stage <= stage + 3'd1;
        3'd5: begin
          // only client so ready is already high here
          if (sqrt_bus.ready) begin
            start_q <= 1'b1;
            stage <= 3'd6;
          end
        end
        3'd6: begin
          start_q <= 1'b0;
          if (sqrt_bus.done) begin
            valid_out <= 1'b1;
            ready_out <= 1'b1;
            stage <= 3'd0;
          end
        end
        default: stage <= 3'd0;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    case (stage)
      3'd0: begin
        if (valid_in) begin
          cam_forward <= cam_forward_in;
          // 2h and 2v so px and py need no extra shift later
          hcount_fp <= fp'(32'(hcount_in) << (num_frac_digits + 1));
          vcount_fp <= fp'(32'(vcount_in) << (num_frac_digits + 1));
        end
      end
      3'd1: cam_right <= vec3_cross(make_vec3(fp_zero, fp_one, fp_zero), cam_forward);
      3'd2: cam_up <= vec3_cross(cam_forward, cam_right);
      3'd3: begin
        px <= mult1_res;
        py <= mult2_res;
      end
      3'd4: begin
        scaled_right <= make_vec3(mult1_res, mult2_res, mult3_res);
        scaled_up <= vec3_scaled(cam_up, py);
      end
      3'd5: begin
        if (sqrt_bus.ready) begin
          rd <= rd_sum;
        end
      end
      3'd6: begin
        if (sqrt_bus.done) begin
          ray_direction_out <= make_vec3(mult1_res, mult2_res, mult3_res);
        end
      end
      default: ;
    endcase
  end

  // sole client of the unit, so it has finished the previous ray by launch
  a_unit_free_at_launch: assert property (@(posedge clk_in) disable iff (rst_in)
    (stage == 3'd5) |-> sqrt_bus.ready);

endmodule

// File: ray_gen_top.sv
module ray_gen_top (
  input logic clk_in,
  input logic rst_in,
  input logic valid_in,
  input logic [ray_pkg::h_bits-1:0] hcount_in,
  input logic [ray_pkg::v_bits-1:0] vcount_in,
  input logic cam_wr_in,
  input ray_pkg::vec3 cam_forward_in,
  output logic ready_out,
  output logic valid_out,
  output ray_pkg::vec3 ray_direction_out
);
  import ray_pkg::*;

  vec3 cam_forward;

  inv_sqrt_if sqrt_bus ();

  camera_regs cam_regs_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .cam_wr_in(cam_wr_in),
    .cam_forward_in(cam_forward_in),
    .gen_ready_in(ready_out),
    .cam_forward_out(cam_forward)
  );

  ray_generator_folded ray_gen_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(valid_in),
    .hcount_in(hcount_in),
    .vcount_in(vcount_in),
    .cam_forward_in(cam_forward),
    .valid_out(valid_out),
    .ready_out(ready_out),
    .ray_direction_out(ray_direction_out),
    .sqrt_bus(sqrt_bus.client)
  );

  fp_inv_sqrt_folded inv_sqrt_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .sqrt_bus(sqrt_bus.server)
  );

endmodule

// File: ray_gen_tb.sv
module ray_gen_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ray_pkg::*;

  localparam int num_fixed_rows = 8;
  localparam int num_random_rows = 4;
  localparam int num_rows = num_fixed_rows + num_random_rows;
  localparam int cycle_limit = (num_rows + 2) * 40;
  // 2^-8 in raw Q16.16 units
  localparam longint tol_raw = 256;

  logic clk_in;
  logic rst_in;
  logic valid_in;
  logic [h_bits-1:0] hcount_in;
  logic [v_bits-1:0] vcount_in;
  logic cam_wr_in;
  vec3 cam_forward_in;
  logic ready_out;
  logic valid_out;
  vec3 ray_direction_out;

  // stimulus and expected values, one row per ray
  string row_name[num_rows];
  logic row_cam_wr[num_rows];
  vec3 row_cam[num_rows];
  int row_h[num_rows];
  int row_v[num_rows];
  logic row_extra[num_rows];
  vec3 row_expected[num_rows];
  int row_count;

  int seed;
  int cycle_count;
  int mismatch_count;
  int other_errors;

  ray_gen_top dut_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(valid_in),
    .hcount_in(hcount_in),
    .vcount_in(vcount_in),
    .cam_wr_in(cam_wr_in),
    .cam_forward_in(cam_forward_in),
    .ready_out(ready_out),
    .valid_out(valid_out),
    .ray_direction_out(ray_direction_out)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  function automatic real to_real(fp f);
    return $itor(f) / $itor(fp_one);
  endfunction

  function automatic fp to_fp(real r);
    return fp'($rtoi(r * $itor(fp_one) + ((r < 0.0) ? -0.5 : 0.5)));
  endfunction

  function automatic vec3 vec_from_reals(real x, real y, real z);
    vec3 v;
    v.x = to_fp(x);
    v.y = to_fp(y);
    v.z = to_fp(z);
    return v;
  endfunction

  // real-valued camera ray, normalized
  function automatic vec3 model_direction(vec3 fwd, int h, int v);
    real fx, fy, fz;
    real rx, ry, rz;
    real ux, uy, uz;
    real px, py;
    real dx, dy, dz;
    real len;
    fx = to_real(fwd.x);
    fy = to_real(fwd.y);
    fz = to_real(fwd.z);
    // right = world up (0, 1, 0) x forward
    rx = fz;
    ry = 0.0;
    rz = -fx;
    // up = forward x right
    ux = fy * rz - fz * ry;
    uy = fz * rx - fx * rz;
    uz = fx * ry - fy * rx;
    px = (2.0 * h - display_width) / display_height;
    py = (2.0 * v - display_height) / display_height;
    dx = rx * px + ux * py + fx;
    dy = ry * px + uy * py + fy;
    dz = rz * px + uz * py + fz;
    len = $sqrt(dx * dx + dy * dy + dz * dz);
    return vec_from_reals(dx / len, dy / len, dz / len);
  endfunction

  task automatic add_row(string name, logic wr, real fx, real fy, real fz,
                         int h, int v, logic extra);
    row_name[row_count] = name;
    row_cam_wr[row_count] = wr;
    row_cam[row_count] = vec_from_reals(fx, fy, fz);
    row_h[row_count] = h;
    row_v[row_count] = v;
    row_extra[row_count] = extra;
    row_count++;
  endtask

  // camera writes land during the row's ray, so they count from the next row on
  task automatic build_table();
    int rand_h;
    int rand_v;
    vec3 cam;
    row_count = 0;
    add_row("centre_reset_cam", 1'b1, 0.3, -0.2, 0.93, 160, 90, 1'b0);
    add_row("corner_top_left", 1'b0, 0.0, 0.0, 0.0, 0, 0, 1'b0);
    add_row("corner_top_right", 1'b0, 0.0, 0.0, 0.0, 319, 0, 1'b1);
    add_row("corner_bottom_left", 1'b1, -0.4, 0.25, 0.88, 0, 179, 1'b0);
    add_row("corner_bottom_right", 1'b0, 0.0, 0.0, 0.0, 319, 179, 1'b0);
    add_row("centre_tilt_b", 1'b1, 0.5, 0.45, 0.7, 160, 90, 1'b1);
    add_row("off_centre_tilt_c", 1'b1, -0.35, -0.3, 0.85, 40, 150, 1'b0);
    add_row("off_centre_tilt_d", 1'b0, 0.0, 0.0, 0.0, 250, 30, 1'b0);
    for (int k = 0; k < num_random_rows; k++) begin
      rand_h = $unsigned($random(seed)) % display_width;
      rand_v = $unsigned($random(seed)) % display_height;
      add_row($sformatf("random_%0d", k), k == 1, 0.2, 0.15, 0.95, rand_h, rand_v, k == 3);
    end
    // expected results follow the camera the DUT should hold per row
    cam = cam_forward_reset;
    for (int i = 0; i < num_rows; i++) begin
      row_expected[i] = model_direction(cam, row_h[i], row_v[i]);
      if (row_cam_wr[i]) begin
        cam = row_cam[i];
      end
    end
  endtask

  task automatic check_fp(string name, fp expected, fp actual);
    longint diff;
    diff = longint'(expected) - longint'(actual);
    if (diff < 0) begin
      diff = -diff;
    end
    if (diff > tol_raw) begin
      mismatch_count++;
      $display("MISMATCH %s: expected %f actual %f", name, to_real(expected), to_real(actual));
    end
  endtask

  task automatic check_vec3(string name, vec3 expected, vec3 actual);
    longint dx, dy, dz;
    dx = longint'(expected.x) - longint'(actual.x);
    dy = longint'(expected.y) - longint'(actual.y);
    dz = longint'(expected.z) - longint'(actual.z);
    if (dx > tol_raw || -dx > tol_raw || dy > tol_raw || -dy > tol_raw ||
        dz > tol_raw || -dz > tol_raw) begin
      mismatch_count++;
      $display("MISMATCH %s: expected (%f, %f, %f) actual (%f, %f, %f)", name,
               to_real(expected.x), to_real(expected.y), to_real(expected.z),
               to_real(actual.x), to_real(actual.y), to_real(actual.z));
    end
  endtask

  task automatic check_level(string name, logic expected, logic actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s: expected %b actual %b", name, expected, actual);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_in);
    #1;
  endtask

  task automatic run_row(int i);
    int waited;
    vec3 held;
    real ax, ay, az;
    check_level({row_name[i], "_ready_idle"}, 1'b1, ready_out);
    valid_in = 1'b1;
    hcount_in = h_bits'(row_h[i]);
    vcount_in = v_bits'(row_v[i]);
    next_cycle();
    valid_in = 1'b0;
    waited = 0;
    // busy until the result marker, watchdog bounds this
    while (!valid_out) begin
      check_level({row_name[i], "_ready_busy"}, 1'b0, ready_out);
      if (waited == 1) begin
        if (row_cam_wr[i]) begin
          cam_wr_in = 1'b1;
          cam_forward_in = row_cam[i];
        end
        if (row_extra[i]) begin
          valid_in = 1'b1;
          hcount_in = h_bits'((row_h[i] + 37) % display_width);
          vcount_in = v_bits'((row_v[i] + 11) % display_height);
        end
      end else if (waited == 2) begin
        cam_wr_in = 1'b0;
        valid_in = 1'b0;
      end
      next_cycle();
      waited++;
    end
    check_level({row_name[i], "_ready_done"}, 1'b1, ready_out);
    check_vec3({row_name[i], "_dir"}, row_expected[i], ray_direction_out);
    ax = to_real(ray_direction_out.x);
    ay = to_real(ray_direction_out.y);
    az = to_real(ray_direction_out.z);
    check_fp({row_name[i], "_len2"}, fp_one, to_fp(ax * ax + ay * ay + az * az));
    // result must hold while idle
    held = ray_direction_out;
    repeat (3) begin
      next_cycle();
      check_level({row_name[i], "_valid_held"}, 1'b1, valid_out);
      check_level({row_name[i], "_ready_held"}, 1'b1, ready_out);
      check_vec3({row_name[i], "_dir_held"}, held, ray_direction_out);
    end
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk_in);
      cycle_count++;
    end
    other_errors++;
    $display("timeout: no result after %0d cycles", cycle_limit);
    $display("summary: %0d mismatches, %0d other errors", mismatch_count, other_errors);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed = 32'hb337_3312;
    mismatch_count = 0;
    other_errors = 0;
    rst_in = 1'b1;
    valid_in = 1'b0;
    hcount_in = '0;
    vcount_in = '0;
    cam_wr_in = 1'b0;
    cam_forward_in = cam_forward_reset;
    build_table();
    repeat (2) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    check_level("reset_ready_out", 1'b1, ready_out);
    check_level("reset_valid_out", 1'b0, valid_out);
    for (int i = 0; i < num_rows; i++) begin
      run_row(i);
    end
    $display("summary: %0d mismatches, %0d other errors", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
ray_pkg.sv
inv_sqrt_if.sv
fp_inv_sqrt_folded.sv
camera_regs.sv
ray_generator_folded.sv
ray_gen_top.sv
ray_gen_tb.sv

// File: Makefile
SRCS := $(shell cat files.f)

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vray_gen_tb: files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module ray_gen_tb -f files.f

sim.log: obj_dir/Vray_gen_tb
	./obj_dir/Vray_gen_tb > sim.log 2>&1 || true

run: obj_dir/Vray_gen_tb
	./obj_dir/Vray_gen_tb 2>&1 | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
